// File: hw/mvr_pkg.sv
// types, FSM states and block constants for the refinement engine
`default_nettype none

package mvr_pkg;

    typedef logic [7:0]         pixel_t;
    // L0 minus L1
    typedef logic signed [8:0]  resid_t;
    typedef logic signed [12:0] coef_t;
    // 16 x 4080 still fits
    typedef logic [15:0]        satd_t;
    typedef logic [3:0]         point_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_MV,
        S_SEARCH,
        S_DRAIN,
        S_OUTPUT
    } state_t;

    localparam int BLK          = 4;
    localparam int NUM_POINTS   = 9;
    localparam int MV_BYTES     = 4;
    // 16 cost bits, then 4 point bits
    localparam int OUT_BITS     = 20;
    // reads still in flight after the last address
    localparam int DRAIN_CYCLES = 4;

endpackage

`default_nettype wire

// File: hw/mvr_ifs.sv
// fetch_if and row_if interfaces between address, memory and cost stages
`timescale 1ns/1ps
`default_nettype none

// one row read for both reference images
interface fetch_if #(
    parameter int IMG_SIZE = 16
);
    localparam int AW = $clog2(2 * IMG_SIZE * IMG_SIZE);

    logic            valid;
    mvr_pkg::point_t point;
    logic            last_row;
    // start pixel of a 4-pixel row
    logic [AW-1:0]   l0_addr;
    logic [AW-1:0]   l1_addr;

    modport src (output valid, point, last_row, l0_addr, l1_addr);
    modport dst (input  valid, point, last_row, l0_addr, l1_addr);
endinterface

// four pixels from each image, tags carried along
interface row_if;
    logic                               valid;
    mvr_pkg::point_t                    point;
    logic                               last_row;
    mvr_pkg::pixel_t [mvr_pkg::BLK-1:0] l0_row;
    mvr_pkg::pixel_t [mvr_pkg::BLK-1:0] l1_row;

    modport src (output valid, point, last_row, l0_row, l1_row);
    modport dst (input  valid, point, last_row, l0_row, l1_row);
endinterface

`default_nettype wire

// File: hw/mvr_fsm.sv
// top-level control FSM of the refinement engine
`timescale 1ns/1ps
`default_nettype none

module mvr_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            in_valid2,
    input  logic            load_done,
    input  logic            mv_done,
    input  logic            search_done,
    input  logic            drain_done,
    input  logic            out_done,
    output mvr_pkg::state_t state
);

    mvr_pkg::state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mvr_pkg::S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // each state leaves on the done pulse of its own counter
    always_comb begin
        next_state = state;
        case (state)
            mvr_pkg::S_IDLE: begin
                if (in_valid) begin
                    next_state = mvr_pkg::S_LOAD;
                end else if (in_valid2) begin
                    next_state = mvr_pkg::S_MV;
                end
            end
            mvr_pkg::S_LOAD: begin
                if (load_done) next_state = mvr_pkg::S_IDLE;
            end
            mvr_pkg::S_MV: begin
                if (mv_done) next_state = mvr_pkg::S_SEARCH;
            end
            mvr_pkg::S_SEARCH: begin
                if (search_done) next_state = mvr_pkg::S_DRAIN;
            end
            mvr_pkg::S_DRAIN: begin
                if (drain_done) next_state = mvr_pkg::S_OUTPUT;
            end
            mvr_pkg::S_OUTPUT: begin
                if (out_done) next_state = mvr_pkg::S_IDLE;
            end
            default: next_state = mvr_pkg::S_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mvr_counters.sv
// load, vector-byte, search, drain and output counters with done pulses
`timescale 1ns/1ps
`default_nettype none

module mvr_counters #(
    parameter int IMG_SIZE = 16,
    localparam int AW = $clog2(2 * IMG_SIZE * IMG_SIZE),
    localparam int OBW = $clog2(mvr_pkg::OUT_BITS)
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mvr_pkg::state_t state,
    input  logic            in_valid,
    input  logic            in_valid2,
    output logic [AW-1:0]   wr_addr,
    output logic [1:0]      mv_idx,
    output logic            rd_en,
    output mvr_pkg::point_t point,
    output logic [1:0]      row,
    output logic            load_done,
    output logic            mv_done,
    output logic            search_done,
    output logic            drain_done,
    output logic            out_done,
    output logic [OBW-1:0]  out_bit
);

    localparam int DW = $clog2(mvr_pkg::DRAIN_CYCLES);

    logic          load_ok;
    logic          mv_ok;
    logic [DW-1:0] drain_cnt;

    // first byte of a transfer still arrives in S_IDLE
    assign load_ok = in_valid && (state == mvr_pkg::S_IDLE || state == mvr_pkg::S_LOAD);
    assign mv_ok   = in_valid2 && (state == mvr_pkg::S_IDLE || state == mvr_pkg::S_MV);
    assign rd_en   = (state == mvr_pkg::S_SEARCH);

    assign load_done   = load_ok && (wr_addr == AW'(2 * IMG_SIZE * IMG_SIZE - 1));
    assign mv_done     = mv_ok && (mv_idx == 2'(mvr_pkg::MV_BYTES - 1));
    assign search_done = rd_en && (point == 4'(mvr_pkg::NUM_POINTS - 1))
                         && (row == 2'(mvr_pkg::BLK - 1));
    assign drain_done  = (state == mvr_pkg::S_DRAIN)
                         && (drain_cnt == DW'(mvr_pkg::DRAIN_CYCLES - 1));
    assign out_done    = (state == mvr_pkg::S_OUTPUT)
                         && (out_bit == OBW'(mvr_pkg::OUT_BITS - 1));

    // ============================================================
    // input side
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
            mv_idx  <= '0;
        end else begin
            if (load_done) begin
                wr_addr <= '0;
            end else if (load_ok) begin
                wr_addr <= wr_addr + 1'b1;
            end
            // four bytes, wraps by itself
            if (mv_ok) mv_idx <= mv_idx + 1'b1;
        end
    end

    // ============================================================
    // search sweep, drain and output
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            point     <= '0;
            row       <= '0;
            drain_cnt <= '0;
            out_bit   <= '0;
        end else begin
            if (!rd_en) begin
                point <= '0;
                row   <= '0;
            end else begin
                row <= row + 1'b1;
                if (row == 2'(mvr_pkg::BLK - 1)) point <= point + 1'b1;
            end
            drain_cnt <= (state == mvr_pkg::S_DRAIN) ? drain_cnt + 1'b1 : '0;
            out_bit   <= (state == mvr_pkg::S_OUTPUT) ? out_bit + 1'b1 : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/search_addr.sv
// motion vector registers and per-row read addresses for L0 and L1
`timescale 1ns/1ps
`default_nettype none

module search_addr #(
    parameter int IMG_SIZE = 16,
    localparam int AW = $clog2(2 * IMG_SIZE * IMG_SIZE)
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid2,
    input  logic [7:0]      in_data,
    input  logic [1:0]      mv_idx,
    input  logic            rd_en,
    input  mvr_pkg::point_t point,
    input  logic [1:0]      row,
    fetch_if.src            fetch
);

    // L0 x, L0 y, L1 x, L1 y
    logic [7:0]    mv [mvr_pkg::MV_BYTES];
    logic [AW-1:0] dx;
    logic [AW-1:0] dy;
    logic [AW-1:0] l0_x;
    logic [AW-1:0] l0_y;
    logic [AW-1:0] l1_x;
    logic [AW-1:0] l1_y;

    always_ff @(posedge clk) begin
        if (in_valid2) mv[mv_idx] <= in_data;
    end

    // point p is column p/3, row p%3 of the 3x3 window
    // L1 moves the opposite way
    always_comb begin
        dx   = AW'(point / 3);
        dy   = AW'(point % 3);
        l0_x = AW'(mv[0]) + dx - AW'(1);
        l0_y = AW'(mv[1]) + dy - AW'(1) + AW'(row);
        l1_x = AW'(mv[2]) - dx + AW'(1);
        l1_y = AW'(mv[3]) - dy + AW'(1) + AW'(row);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= rd_en;
        end
    end

    // L1 lives in the upper half of the pixel store
    always_ff @(posedge clk) begin
        if (rd_en) begin
            fetch.point    <= point;
            fetch.last_row <= (row == 2'(mvr_pkg::BLK - 1));
            fetch.l0_addr  <= l0_y * AW'(IMG_SIZE) + l0_x;
            fetch.l1_addr  <= l1_y * AW'(IMG_SIZE) + l1_x + AW'(IMG_SIZE * IMG_SIZE);
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_mem.sv
// two-image pixel store, serial write and dual 4-pixel row read
`timescale 1ns/1ps
`default_nettype none

module pixel_mem #(
    parameter int IMG_SIZE = 16,
    localparam int AW = $clog2(2 * IMG_SIZE * IMG_SIZE),
    localparam int DEPTH = 2 * IMG_SIZE * IMG_SIZE
) (
    input  logic          clk,
    input  logic          in_valid,
    input  logic [7:0]    in_data,
    input  logic [AW-1:0] wr_addr,
    fetch_if.dst          fetch,
    row_if.src            rows
);

    // L0 row-major, then L1
    mvr_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (in_valid) mem[wr_addr] <= in_data;
    end

    // one-cycle read, tags follow the data
    always_ff @(posedge clk) begin
        rows.valid <= fetch.valid;
        if (fetch.valid) begin
            rows.point    <= fetch.point;
            rows.last_row <= fetch.last_row;
            for (int i = 0; i < mvr_pkg::BLK; i++) begin
                rows.l0_row[i] <= mem[fetch.l0_addr + AW'(i)];
                rows.l1_row[i] <= mem[fetch.l1_addr + AW'(i)];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/satd_unit.sv
// residual, row and column hadamard passes and per-point SATD
`timescale 1ns/1ps
`default_nettype none

module satd_unit (
    input  logic            clk,
    input  logic            rst_n,
    row_if.dst              rows,
    output logic            satd_valid,
    output mvr_pkg::satd_t  satd,
    output mvr_pkg::point_t satd_point
);

    typedef mvr_pkg::coef_t quad_t [mvr_pkg::BLK];

    quad_t           resid;
    quad_t           rp [mvr_pkg::BLK];
    logic [1:0]      row_idx;
    logic            col_go;
    mvr_pkg::point_t col_point;
    mvr_pkg::satd_t  sum;

    // 4-point butterfly, same for rows and columns
    function automatic quad_t had4(input quad_t a);
        quad_t y;
        y[0] = a[0] + a[1] + a[2] + a[3];
        y[1] = a[0] - a[1] + a[2] - a[3];
        y[2] = a[0] + a[1] - a[2] - a[3];
        y[3] = a[0] - a[1] - a[2] + a[3];
        return y;
    endfunction

    function automatic mvr_pkg::satd_t abs_coef(input mvr_pkg::coef_t c);
        return mvr_pkg::satd_t'($unsigned((c < 0) ? -c : c));
    endfunction

    always_comb begin
        for (int i = 0; i < mvr_pkg::BLK; i++) begin
            resid[i] = mvr_pkg::coef_t'(mvr_pkg::resid_t'(
                {1'b0, rows.l0_row[i]} - {1'b0, rows.l1_row[i]}));
        end
    end

    // ============================================================
    // row pass
    // ============================================================
    always_ff @(posedge clk) begin
        if (rows.valid) begin
            rp[row_idx] <= had4(resid);
            col_point   <= rows.point;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_idx    <= '0;
            col_go     <= 1'b0;
            satd_valid <= 1'b0;
        end else begin
            if (rows.valid) row_idx <= rows.last_row ? 2'd0 : row_idx + 1'b1;
            col_go     <= rows.valid && rows.last_row;
            satd_valid <= col_go;
        end
    end

    // ============================================================
    // column pass and sum
    // ============================================================
    always_comb begin
        quad_t col;
        quad_t coef;
        sum = '0;
        for (int c = 0; c < mvr_pkg::BLK; c++) begin
            for (int r = 0; r < mvr_pkg::BLK; r++) col[r] = rp[r][c];
            coef = had4(col);
            for (int k = 0; k < mvr_pkg::BLK; k++) sum = sum + abs_coef(coef[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (col_go) begin
            satd       <= sum;
            satd_point <= col_point;
        end
    end

endmodule

`default_nettype wire

// File: hw/best_select.sv
// minimum-cost tracking and serial result shifter
`timescale 1ns/1ps
`default_nettype none

module best_select #(
    localparam int OBW = $clog2(mvr_pkg::OUT_BITS)
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mvr_pkg::state_t state,
    input  logic            satd_valid,
    input  mvr_pkg::satd_t  satd,
    input  mvr_pkg::point_t satd_point,
    input  logic [OBW-1:0]  out_bit,
    output logic            out_valid,
    output logic            out_sad
);

    mvr_pkg::satd_t               best_cost;
    mvr_pkg::point_t              best_point;
    logic [mvr_pkg::OUT_BITS-1:0] result;

    // strictly lower wins, so ties keep the lower index
    always_ff @(posedge clk) begin
        if (state == mvr_pkg::S_MV) begin
            best_cost  <= '1;
            best_point <= '0;
        end else if (satd_valid && (satd < best_cost)) begin
            best_cost  <= satd;
            best_point <= satd_point;
        end
    end

    // cost goes out lsb first, point in the last four bits
    assign result = {best_point, best_cost};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
        end else begin
            out_valid <= (state == mvr_pkg::S_OUTPUT);
            out_sad   <= (state == mvr_pkg::S_OUTPUT) && result[out_bit];
        end
    end

endmodule

`default_nettype wire

// File: hw/mvr_top.sv
// refinement engine top level, plain ports and block instances
`timescale 1ns/1ps
`default_nettype none

module mvr_top #(
    parameter int IMG_SIZE = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       in_valid2,
    input  logic [7:0] in_data,
    output logic       out_valid,
    output logic       out_sad
);

    localparam int AW  = $clog2(2 * IMG_SIZE * IMG_SIZE);
    localparam int OBW = $clog2(mvr_pkg::OUT_BITS);

    mvr_pkg::state_t state;
    logic            load_done;
    logic            mv_done;
    logic            search_done;
    logic            drain_done;
    logic            out_done;
    logic [AW-1:0]   wr_addr;
    logic [1:0]      mv_idx;
    logic            rd_en;
    mvr_pkg::point_t point;
    logic [1:0]      row;
    logic [OBW-1:0]  out_bit;
    logic            satd_valid;
    mvr_pkg::satd_t  satd;
    mvr_pkg::point_t satd_point;

    fetch_if #(.IMG_SIZE(IMG_SIZE)) fetch ();
    row_if rows ();

    // ============================================================
    // control
    // ============================================================
    mvr_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_valid2   (in_valid2),
        .load_done   (load_done),
        .mv_done     (mv_done),
        .search_done (search_done),
        .drain_done  (drain_done),
        .out_done    (out_done),
        .state       (state)
    );

    mvr_counters #(.IMG_SIZE(IMG_SIZE)) u_counters (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .in_valid    (in_valid),
        .in_valid2   (in_valid2),
        .wr_addr     (wr_addr),
        .mv_idx      (mv_idx),
        .rd_en       (rd_en),
        .point       (point),
        .row         (row),
        .load_done   (load_done),
        .mv_done     (mv_done),
        .search_done (search_done),
        .drain_done  (drain_done),
        .out_done    (out_done),
        .out_bit     (out_bit)
    );

    // ============================================================
    // datapath, address -> memory -> cost -> select
    // ============================================================
    search_addr #(.IMG_SIZE(IMG_SIZE)) u_search_addr (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid2 (in_valid2),
        .in_data   (in_data),
        .mv_idx    (mv_idx),
        .rd_en     (rd_en),
        .point     (point),
        .row       (row),
        .fetch     (fetch.src)
    );

    pixel_mem #(.IMG_SIZE(IMG_SIZE)) u_pixel_mem (
        .clk      (clk),
        .in_valid (in_valid),
        .in_data  (in_data),
        .wr_addr  (wr_addr),
        .fetch    (fetch.dst),
        .rows     (rows.src)
    );

    satd_unit u_satd (
        .clk        (clk),
        .rst_n      (rst_n),
        .rows       (rows.dst),
        .satd_valid (satd_valid),
        .satd       (satd),
        .satd_point (satd_point)
    );

    best_select u_best (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .satd_valid (satd_valid),
        .satd       (satd),
        .satd_point (satd_point),
        .out_bit    (out_bit),
        .out_valid  (out_valid),
        .out_sad    (out_sad)
    );

endmodule

`default_nettype wire

// File: dv/tb_mvr_checker.sv
// result monitor with image and vector capture and a SATD reference model
`timescale 1ns/1ps
`default_nettype none

module tb_mvr_checker #(
    parameter int IMG_SIZE = 16
) (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       in_valid2,
    input logic [7:0] in_data,
    input logic       out_valid,
    input logic       out_sad
);

    localparam int NPIX     = 2 * IMG_SIZE * IMG_SIZE;
    localparam int MAX_WAIT = 100;

    // written by the testbench top before each vector transfer
    string test_name = "none";
    int    pass_count = 0;
    int    fail_count = 0;

    logic [7:0]                   img [NPIX];
    logic [7:0]                   mv [mvr_pkg::MV_BYTES];
    logic [mvr_pkg::OUT_BITS-1:0] got;
    int                           load_idx = 0;
    int                           mv_cnt = 0;
    bit                           pending = 1'b0;
    int                           wait_cycles = 0;
    int                           nbits = 0;
    string                        exp_name;
    int                           exp_cost;
    int                           exp_point;

    // sign of hadamard basis k at sample i
    function automatic int hsign(input logic [1:0] k, input logic [1:0] i);
        return (^(k & i)) ? -1 : 1;
    endfunction

    function automatic int pix(input int image, input int x, input int y);
        return int'(img[image * IMG_SIZE * IMG_SIZE + y * IMG_SIZE + x]);
    endfunction

    // mirrored 4x4 blocks, 2-D transform, sum of magnitudes
    function automatic int point_cost(input int p);
        int dx;
        int dy;
        int coef;
        int cost;
        dx   = p / 3 - 1;
        dy   = p % 3 - 1;
        cost = 0;
        for (int u = 0; u < 4; u++) begin
            for (int v = 0; v < 4; v++) begin
                coef = 0;
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        coef += hsign(u[1:0], r[1:0]) * hsign(v[1:0], c[1:0])
                                * (pix(0, int'(mv[0]) + dx + c, int'(mv[1]) + dy + r)
                                   - pix(1, int'(mv[2]) - dx + c, int'(mv[3]) - dy + r));
                    end
                end
                cost += (coef < 0) ? -coef : coef;
            end
        end
        return cost;
    endfunction

    // strictly lower wins, ties keep the lower point
    task automatic predict();
        int cost;
        exp_cost  = 65535;
        exp_point = 0;
        for (int p = 0; p < mvr_pkg::NUM_POINTS; p++) begin
            cost = point_cost(p);
            if (cost < exp_cost) begin
                exp_cost  = cost;
                exp_point = p;
            end
        end
    endtask

    task automatic finish_result();
        int act_cost;
        int act_point;
        act_cost  = int'(got[15:0]);
        act_point = int'(got[19:16]);
        if (!pending) begin
            $display("out_valid burst of %0d cycles with no search pending", nbits);
            fail_count++;
        end else if (nbits != mvr_pkg::OUT_BITS) begin
            $display("%s: out_valid lasted %0d cycles instead of %0d",
                     exp_name, nbits, mvr_pkg::OUT_BITS);
            fail_count++;
        end else if (act_cost != exp_cost || act_point != exp_point) begin
            $display("Mismatch %s: expected point %0d satd %0d, actual point %0d satd %0d",
                     exp_name, exp_point, exp_cost, act_point, act_cost);
            fail_count++;
        end else begin
            $display("ok %s: point %0d satd %0d", exp_name, act_point, act_cost);
            pass_count++;
        end
        pending = 1'b0;
    endtask

    // ============================================================
    // sampling on the rising edge, before the DUT updates
    // ============================================================
    always @(posedge clk) begin
        if (rst_n) begin
            if (!out_valid && out_sad) begin
                $display("out_sad is high while out_valid is low");
                fail_count++;
            end
            if (out_valid) begin
                if (nbits < mvr_pkg::OUT_BITS) got[nbits] = out_sad;
                nbits++;
            end else if (nbits != 0) begin
                finish_result();
                nbits = 0;
            end else if (pending) begin
                wait_cycles++;
                if (wait_cycles >= MAX_WAIT) begin
                    $display("%s: no out_valid within %0d cycles of the last vector byte",
                             exp_name, MAX_WAIT);
                    fail_count++;
                    pending = 1'b0;
                end
            end
            if (in_valid) begin
                img[load_idx] = in_data;
                load_idx      = (load_idx + 1) % NPIX;
            end
            if (in_valid2) begin
                mv[mv_cnt] = in_data;
                mv_cnt     = (mv_cnt + 1) % mvr_pkg::MV_BYTES;
                if (mv_cnt == 0) begin
                    exp_name = test_name;
                    predict();
                    pending     = 1'b1;
                    wait_cycles = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_mvr.sv
// testbench top with clock, reset, stimulus table, watchdog and final report
`timescale 1ns/1ps
`default_nettype none

module tb_mvr;

    localparam int          IMG_SIZE  = 16;
    localparam int          NPIX      = 2 * IMG_SIZE * IMG_SIZE;
    localparam int          NUM_TESTS = 8;
    localparam int          HI        = IMG_SIZE - 5;
    localparam int          WATCHDOG  = 2 * NUM_TESTS * (NPIX + 200);
    localparam logic [31:0] SEED      = 32'h718c_8117;

    typedef enum int {IMG_RANDOM, IMG_FLAT, IMG_KEEP} img_mode_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_valid2;
    logic [7:0] in_data;
    logic       out_valid;
    logic       out_sad;

    // ============================================================
    // stimulus table with vectors packed as L0 x, L0 y, L1 x, L1 y
    // ============================================================
    string names [NUM_TESTS] = '{"random_center", "tie_flat_pos", "tie_flat_neg",
        "edge_low", "edge_high", "edge_mixed", "reuse_new_mv", "reload_random"};
    img_mode_t modes [NUM_TESTS] = '{IMG_RANDOM, IMG_FLAT, IMG_FLAT,
        IMG_RANDOM, IMG_KEEP, IMG_KEEP, IMG_KEEP, IMG_RANDOM};
    int flat_c [NUM_TESTS] = '{0, 5, -7, 0, 0, 0, 0, 0};
    logic [31:0] vecs [NUM_TESTS] = '{
        {8'd6, 8'd6, 8'd6, 8'd6},
        {8'd6, 8'd6, 8'd7, 8'd5},
        {8'd3, 8'd9, 8'd8, 8'd2},
        {8'd1, 8'd1, 8'd1, 8'd1},
        {8'(HI), 8'(HI), 8'(HI), 8'(HI)},
        {8'd1, 8'(HI), 8'(HI), 8'd1},
        {8'd4, 8'd7, 8'd9, 8'd2},
        {8'd8, 8'd3, 8'd5, 8'd10}
    };

    mvr_top #(.IMG_SIZE(IMG_SIZE)) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

    tb_mvr_checker #(.IMG_SIZE(IMG_SIZE)) chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // flat mode keeps every residual at c
    task automatic load_images(input img_mode_t mode, input int c);
        logic [7:0] pixel;
        int         k;
        for (k = 0; k < NPIX; k++) begin
            if (mode == IMG_RANDOM) pixel = 8'($urandom);
            else if (k < NPIX / 2) pixel = 8'd120;
            else pixel = 8'(120 - c);
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= pixel;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_data  <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic send_vectors(input logic [31:0] vec);
        int b;
        for (b = 3; b >= 0; b--) begin
            @(posedge clk);
            in_valid2 <= 1'b1;
            in_data   <= vec[b*8 +: 8];
        end
        @(posedge clk);
        in_valid2 <= 1'b0;
        in_data   <= '0;
    endtask

    // wait for the result burst to start and then to end
    task automatic wait_result();
        int n;
        n = 0;
        while (out_valid !== 1'b1 && n < 120) begin
            @(posedge clk);
            n++;
        end
        n = 0;
        while (out_valid === 1'b1 && n < 40) begin
            @(posedge clk);
            n++;
        end
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int t;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_valid2 = 1'b0;
        in_data   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (t = 0; t < NUM_TESTS; t++) begin
            if (modes[t] != IMG_KEEP) load_images(modes[t], flat_c[t]);
            chk.test_name = names[t];
            send_vectors(vecs[t]);
            wait_result();
        end
        repeat (4) @(posedge clk);
        $display("tests %0d, passed %0d, errors %0d", NUM_TESTS, chk.pass_count,
                 chk.fail_count);
        if (chk.fail_count == 0 && chk.pass_count == NUM_TESTS) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // limit scales with the image load length of every test
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/mvr_pkg.sv
hw/mvr_ifs.sv
hw/mvr_fsm.sv
hw/mvr_counters.sv
hw/search_addr.sv
hw/pixel_mem.sv
hw/satd_unit.sv
hw/best_select.sv
hw/mvr_top.sv
dv/tb_mvr_checker.sv
dv/tb_mvr.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_mvr
RTL_TOP  := mvr_top
FILELIST := files.f
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
